// File: flist.f
+incdir+include
logic/otp_lc_pkg.sv
logic/otp_word_counter.sv
logic/otp_lc_prog.sv
logic/otp_fuse_array.sv
logic/otp_lc_top.sv
test/otp_lc_tb.sv
test/otp_lc_properties.sv

// File: Makefile
# Verilator simulation of the OTP life cycle programming path

VERILATOR ?= verilator
TOP       ?= otp_lc_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

.PHONY: sim clean

# The run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/otp_lc_properties.sv
/*
 * Protocol checks for the life cycle programming FSM
 */

`timescale 1ns/1ps
`default_nettype none

`include "otp_lc_cfg.svh"

module otp_lc_properties (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      idle_i,
  input logic                      req_i,
  input logic                      ack_i,
  input logic                      cnt_err_i,
  input logic [`OTP_LC_WORD_W-1:0] wdata_i
);

  // Idle means no array traffic
  no_req_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    idle_i |-> !req_i) else $error("Array request raised while idle");

  // Acknowledge is a single-cycle pulse
  ack_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_i |=> !ack_i) else $error("Acknowledge held for two cycles");

  // Both counter copies must stay consistent
  no_cnt_err: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !cnt_err_i) else $error("Word counter copies disagree");

  // Write data bus quiet without a request
  wdata_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !req_i |-> wdata_i == '0) else $error("Write data driven without request");

endmodule

bind otp_lc_prog otp_lc_properties i_props (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .idle_i    (lci_prog_idle_o),
  .req_i     (otp_req_o),
  .ack_i     (lc_ack_o),
  .cnt_err_i (cnt_err),
  .wdata_i   (otp_wdata_o)
);

`default_nettype wire

// File: test/otp_lc_tb.sv
/*
 * Testbench for the life cycle programming path
 * Random transitions checked against a fuse model, error and escalation cases
 */

`timescale 1ns/1ps
`default_nettype none

`include "otp_lc_cfg.svh"

module otp_lc_tb
  import otp_lc_pkg::*;
();

  localparam int words       = `OTP_LC_NUM_WORDS;
  localparam int ww          = `OTP_LC_WORD_W;
  localparam int lc_w        = words * ww;
  localparam int word_cycles = 1 + `OTP_LC_RSP_DELAY;
  // One spare cycle per word before giving up on an acknowledge
  localparam int ack_limit   = words * (word_cycles + 1);
  localparam int esc_window  = (words - 1) * word_cycles;
  localparam int max_cycles  = 200 * words * 4 + 800;
  localparam int n_blank     = 40;
  localparam int n_up        = 80;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      lci_en_i;
  lc_tx_e                    escalate_en_i;
  logic                      lc_req_i;
  logic [lc_w-1:0]           lc_data_i;
  logic                      lc_ack_o;
  logic                      lc_err_o;
  otp_err_e                  error_o;
  logic                      fsm_err_o;
  logic                      lci_prog_idle_o;
  logic [`OTP_LC_ADDR_W-1:0] rd_addr_i;
  logic [ww-1:0]             rd_data_o;

  // Expected fuse contents of the life cycle words
  logic [ww-1:0] fuse_m [words];
  logic [31:0]   rng_state = 32'd92705;
  int            errors;
  int            checks;

  otp_lc_top i_otp_lc_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lci_en_i        (lci_en_i),
    .escalate_en_i   (escalate_en_i),
    .lc_req_i        (lc_req_i),
    .lc_data_i       (lc_data_i),
    .lc_ack_o        (lc_ack_o),
    .lc_err_o        (lc_err_o),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o),
    .lci_prog_idle_o (lci_prog_idle_o),
    .rd_addr_i       (rd_addr_i),
    .rd_data_o       (rd_data_o)
  );

  always #4 clk_i = ~clk_i;

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [lc_w-1:0] rand_value();
    return lc_w'({next_rand(), next_rand()});
  endfunction

  // A word that would clear a burnt bit stays as it is and the others are ORed in
  function automatic logic model_burn(input logic [lc_w-1:0] val);
    logic          fail;
    logic [ww-1:0] nw;
    fail = 1'b0;
    for (int w = 0; w < words; w++) begin
      nw = val[w*ww +: ww];
      if ((fuse_m[w] & ~nw) != '0) begin
        fail = 1'b1;
      end else begin
        fuse_m[w] = fuse_m[w] | nw;
      end
    end
    return fail;
  endfunction

  function automatic logic [lc_w-1:0] model_value();
    logic [lc_w-1:0] v;
    for (int w = 0; w < words; w++) begin
      v[w*ww +: ww] = fuse_m[w];
    end
    return v;
  endfunction

  task automatic check_val(input string name, input logic [lc_w-1:0] got,
                           input logic [lc_w-1:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_val(name, lc_w'(got), lc_w'(exp));
  endtask

  task automatic check_cond(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  task automatic reset_dut();
    @(posedge clk_i);
    #1;
    rst_ni        = 1'b0;
    lci_en_i      = 1'b0;
    lc_req_i      = 1'b0;
    escalate_en_i = LcOff;
    rd_addr_i     = '0;
    for (int w = 0; w < words; w++) begin
      fuse_m[w] = '0;
    end
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_bit("lc_ack_o", lc_ack_o, 1'b0);
    check_bit("lc_err_o", lc_err_o, 1'b0);
    check_bit("fsm_err_o", fsm_err_o, 1'b0);
    check_val("error_o", lc_w'(error_o), lc_w'(NoError));
    check_bit("lci_prog_idle_o", lci_prog_idle_o, 1'b0);
  endtask

  // Idle comes one edge after the enable
  task automatic enable_dut();
    @(posedge clk_i);
    #1;
    lci_en_i = 1'b1;
    @(negedge clk_i);
    check_bit("lci_prog_idle_o", lci_prog_idle_o, 1'b0);
    @(negedge clk_i);
    check_bit("lci_prog_idle_o", lci_prog_idle_o, 1'b1);
  endtask

  task automatic start_request(input logic [lc_w-1:0] data);
    @(posedge clk_i);
    #1;
    lc_data_i = data;
    lc_req_i  = 1'b1;
    @(posedge clk_i);
    #1;
    lc_req_i = 1'b0;
  endtask

  task automatic wait_ack(output logic acked, output logic errd);
    int n;
    acked = 1'b0;
    errd  = 1'b0;
    n     = 0;
    while (!acked && n < ack_limit) begin
      @(negedge clk_i);
      n++;
      if (lc_ack_o) begin
        acked = 1'b1;
        errd  = lc_err_o;
      end
    end
  endtask

  task automatic read_fuses(output logic [lc_w-1:0] val);
    for (int w = 0; w < words; w++) begin
      @(posedge clk_i);
      #1;
      rd_addr_i = `OTP_LC_ADDR_W'(`OTP_LC_OFFSET + w);
      @(negedge clk_i);
      val[w*ww +: ww] = rd_data_o;
    end
  endtask

  // Burn one value and compare acknowledge, error flag and readback with the model
  task automatic burn_and_check(input logic [lc_w-1:0] data);
    logic            fail_exp;
    logic            acked;
    logic            errd;
    logic [lc_w-1:0] rb;
    fail_exp = model_burn(data);
    start_request(data);
    wait_ack(acked, errd);
    check_cond(acked, "transition got no acknowledge");
    check_bit("lc_err_o", errd, fail_exp);
    read_fuses(rb);
    check_val("rd_data_o", rb, model_value());
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("Test %s done with %0d errors", name, errors - err_start);
  endtask

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Run did not finish within %0d cycles", max_cycles);
    $display("Something failed");
    $finish;
  end

  ////////////////////
  // Tests
  ////////////////////

  initial begin
    logic [lc_w-1:0] data;
    logic [lc_w-1:0] rb;
    logic [lc_w-1:0] expv;
    logic            acked;
    logic            errd;
    logic [3:0]      esc;
    int              start;
    int              k;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    lci_en_i      = 1'b0;
    escalate_en_i = LcOff;
    lc_req_i      = 1'b0;
    lc_data_i     = '0;
    rd_addr_i     = '0;
    errors        = 0;
    checks        = 0;

    // Idle stays low until enabled
    start = errors;
    reset_dut();
    repeat (3) begin
      @(negedge clk_i);
      check_bit("lci_prog_idle_o", lci_prog_idle_o, 1'b0);
    end
    enable_dut();
    report_test("reset_enable", start);

    // Each value into freshly blank fuses
    start = errors;
    repeat (n_blank) begin
      reset_dut();
      enable_dut();
      burn_and_check(rand_value());
      check_val("error_o", lc_w'(error_o), lc_w'(NoError));
    end
    report_test("blank_prog", start);

    // Sparse extra ones on top of the stored value
    start = errors;
    reset_dut();
    enable_dut();
    repeat (n_up) begin
      burn_and_check(model_value() | (rand_value() & rand_value()));
    end
    check_val("error_o", lc_w'(error_o), lc_w'(NoError));
    report_test("upward", start);

    // Bit 0 is burnt first and later cleared while the other words gain ones
    start = errors;
    reset_dut();
    enable_dut();
    burn_and_check(rand_value() | lc_w'(1));
    burn_and_check((model_value() | rand_value()) & ~lc_w'(1));
    check_val("error_o", lc_w'(error_o), lc_w'(WriteBlankError));
    start_request(rand_value());
    wait_ack(acked, errd);
    check_cond(!acked, "request after a failed transition was acknowledged");
    check_bit("lci_prog_idle_o", lci_prog_idle_o, 1'b0);
    report_test("clear_bit", start);

    // Escalate k cycles into a transition
    start = errors;
    reset_dut();
    enable_dut();
    data = rand_value();
    k    = int'(next_rand() % 32'(esc_window));
    esc  = 4'(next_rand());
    while (esc == 4'(LcOff)) begin
      esc = 4'(next_rand());
    end
    start_request(data);
    repeat (k) begin
      @(posedge clk_i);
      #1;
    end
    escalate_en_i = lc_tx_e'(esc);
    @(negedge clk_i);
    check_bit("fsm_err_o", fsm_err_o, 1'b1);
    wait_ack(acked, errd);
    check_cond(!acked, "transition was acknowledged after escalation");
    check_val("error_o", lc_w'(error_o), lc_w'(FsmStateError));
    // Words whose write cycle came after the escalation stay blank
    for (int w = 0; w < words; w++) begin
      expv[w*ww +: ww] = (w * word_cycles <= k) ? data[w*ww +: ww] : '0;
    end
    read_fuses(rb);
    check_val("rd_data_o", rb, expv);
    report_test("escalation", start);

    $display("Tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/otp_lc_top.sv
/*
 * Life cycle programming path top level
 * Programming FSM driving the fuse array, with fuse readback brought out
 */

`timescale 1ns/1ps
`default_nettype none

`include "otp_lc_cfg.svh"

module otp_lc_top
  import otp_lc_pkg::*;
(
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       lci_en_i,
  input  lc_tx_e                                     escalate_en_i,
  // Life cycle controller side
  input  logic                                       lc_req_i,
  input  logic [`OTP_LC_NUM_WORDS*`OTP_LC_WORD_W-1:0] lc_data_i,
  output logic                                       lc_ack_o,
  output logic                                       lc_err_o,
  // Status
  output otp_err_e                                   error_o,
  output logic                                       fsm_err_o,
  output logic                                       lci_prog_idle_o,
  // Fuse readback
  input  logic [`OTP_LC_ADDR_W-1:0]                  rd_addr_i,
  output logic [`OTP_LC_WORD_W-1:0]                  rd_data_o
);

  // FSM to array
  logic                      otp_req;
  otp_cmd_e                  otp_cmd;
  logic [`OTP_LC_ADDR_W-1:0] otp_addr;
  logic [`OTP_LC_WORD_W-1:0] otp_wdata;
  // Array to FSM
  logic                      otp_gnt;
  logic                      otp_rvalid;
  otp_err_e                  otp_err;

  otp_lc_prog i_prog (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lci_en_i        (lci_en_i),
    .escalate_en_i   (escalate_en_i),
    .lc_req_i        (lc_req_i),
    .lc_data_i       (lc_data_i),
    .lc_ack_o        (lc_ack_o),
    .lc_err_o        (lc_err_o),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o),
    .lci_prog_idle_o (lci_prog_idle_o),
    .otp_req_o       (otp_req),
    .otp_cmd_o       (otp_cmd),
    .otp_addr_o      (otp_addr),
    .otp_wdata_o     (otp_wdata),
    .otp_gnt_i       (otp_gnt),
    .otp_rvalid_i    (otp_rvalid),
    .otp_err_i       (otp_err)
  );

  otp_fuse_array i_fuses (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (otp_req),
    .cmd_i     (otp_cmd),
    .addr_i    (otp_addr),
    .wdata_i   (otp_wdata),
    .gnt_o     (otp_gnt),
    .rvalid_o  (otp_rvalid),
    .err_o     (otp_err),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o)
  );

endmodule

`default_nettype wire

// File: logic/otp_fuse_array.sv
/*
 * Write-once fuse array model
 * Request/grant port with delayed response and a combinational readback port
 */

`timescale 1ns/1ps
`default_nettype none

`include "otp_lc_cfg.svh"

module otp_fuse_array
  import otp_lc_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Command port
  input  logic                      req_i,
  input  otp_cmd_e                  cmd_i,
  input  logic [`OTP_LC_ADDR_W-1:0] addr_i,
  input  logic [`OTP_LC_WORD_W-1:0] wdata_i,
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output otp_err_e                  err_o,
  // Readback port
  input  logic [`OTP_LC_ADDR_W-1:0] rd_addr_i,
  output logic [`OTP_LC_WORD_W-1:0] rd_data_o
);

  localparam int dly = `OTP_LC_RSP_DELAY;

  // Fuse words, blank after reset
  logic [`OTP_LC_WORD_W-1:0] fuse_q [`OTP_LC_DEPTH];

  // Response pipeline
  logic     [dly-1:0] valid_q;
  otp_err_e           err_q [dly];

  logic     pending;
  logic     accept;
  logic     clears_bit;
  otp_err_e cmd_err;

  ////////////////////
  // Command decode
  ////////////////////

  // One command in flight at a time
  assign pending = |valid_q;
  assign gnt_o   = req_i & ~pending;
  assign accept  = req_i & gnt_o;

  // A 0 over a burnt 1 cannot be programmed
  assign clears_bit = |(fuse_q[addr_i] & ~wdata_i);

  always_comb begin
    cmd_err = NoError;
    if (cmd_i == CmdWrite && clears_bit) begin
      cmd_err = WriteBlankError;
    end
  end

  ////////////////////
  // Fuse storage
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `OTP_LC_DEPTH; i++) begin
        fuse_q[i] <= '0;
      end
    end else if (accept && cmd_i == CmdWrite && !clears_bit) begin
      // Fuses only ever gain ones
      fuse_q[addr_i] <= fuse_q[addr_i] | wdata_i;
    end
  end

  ////////////////////
  // Response delay
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      for (int i = 0; i < dly; i++) begin
        err_q[i] <= NoError;
      end
    end else begin
      valid_q[0] <= accept;
      err_q[0]   <= cmd_err;
      for (int i = 1; i < dly; i++) begin
        valid_q[i] <= valid_q[i-1];
        err_q[i]   <= err_q[i-1];
      end
    end
  end

  assign rvalid_o = valid_q[dly-1];
  assign err_o    = err_q[dly-1];

  // Readback follows the address in the same cycle
  assign rd_data_o = fuse_q[rd_addr_i];

endmodule

`default_nettype wire

// File: logic/otp_lc_prog.sv
/*
 * Life cycle programming FSM
 * Burns a new life cycle value into OTP word by word and reports the result
 */

`timescale 1ns/1ps
`default_nettype none

`include "otp_lc_cfg.svh"

module otp_lc_prog
  import otp_lc_pkg::*;
(
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       lci_en_i,
  input  lc_tx_e                                     escalate_en_i,
  // Transition request from the life cycle controller
  input  logic                                       lc_req_i,
  input  logic [`OTP_LC_NUM_WORDS*`OTP_LC_WORD_W-1:0] lc_data_i,
  output logic                                       lc_ack_o,
  output logic                                       lc_err_o,
  // Status
  output otp_err_e                                   error_o,
  output logic                                       fsm_err_o,
  output logic                                       lci_prog_idle_o,
  // Fuse array port
  output logic                                       otp_req_o,
  output otp_cmd_e                                   otp_cmd_o,
  output logic [`OTP_LC_ADDR_W-1:0]                  otp_addr_o,
  output logic [`OTP_LC_WORD_W-1:0]                  otp_wdata_o,
  input  logic                                       otp_gnt_i,
  input  logic                                       otp_rvalid_i,
  input  otp_err_e                                   otp_err_i
);

  localparam int cnt_w = $clog2(`OTP_LC_NUM_WORDS);
  localparam int unsigned last_word_int = `OTP_LC_NUM_WORDS - 1;
  localparam logic [cnt_w-1:0] last_word = last_word_int[cnt_w-1:0];

  ////////////////////
  // State encoding
  ////////////////////

  // 9-bit codes, pairwise Hamming distance of at least 5
  typedef enum logic [8:0] {
    ResetSt     = 9'b000101011,
    IdleSt      = 9'b110011110,
    WriteSt     = 9'b101010001,
    WriteWaitSt = 9'b010000000,
    ErrorSt     = 9'b011111101
  } state_e;

  state_e state_d, state_q;
  otp_err_e error_d, error_q;

  logic             cnt_clr;
  logic             cnt_incr;
  logic             cnt_err;
  logic [cnt_w-1:0] cnt;

  // Life cycle value split into native words
  logic [`OTP_LC_NUM_WORDS-1:0][`OTP_LC_WORD_W-1:0] data;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d         = state_q;
    error_d         = error_q;
    cnt_clr         = 1'b0;
    cnt_incr        = 1'b0;
    lci_prog_idle_o = 1'b1;
    otp_req_o       = 1'b0;
    otp_cmd_o       = CmdRead;
    lc_ack_o        = 1'b0;
    lc_err_o        = 1'b0;
    fsm_err_o       = 1'b0;

    unique case (state_q)
      // Hold here until the interface is enabled
      ResetSt: begin
        lci_prog_idle_o = 1'b0;
        if (lci_en_i) begin
          state_d = IdleSt;
        end
      end
      // Wait for a transition request
      IdleSt: begin
        if (lc_req_i) begin
          state_d = WriteSt;
          cnt_clr = 1'b1;
        end
      end
      // Request stays up until granted
      WriteSt: begin
        lci_prog_idle_o = 1'b0;
        otp_req_o       = 1'b1;
        otp_cmd_o       = CmdWrite;
        if (otp_gnt_i) begin
          state_d = WriteWaitSt;
        end
      end
      // Collect the response of the current word
      WriteWaitSt: begin
        lci_prog_idle_o = 1'b0;
        if (otp_rvalid_i) begin
          // Keep the latest failure but carry on with the other words
          if (otp_err_i != NoError) begin
            error_d = otp_err_i;
          end
          if (cnt == last_word) begin
            lc_ack_o = 1'b1;
            state_d  = IdleSt;
            if (error_d != NoError) begin
              lc_err_o = 1'b1;
              state_d  = ErrorSt;
            end
          end else begin
            cnt_incr = 1'b1;
            state_d  = WriteSt;
          end
        end
      end
      // Terminal state, no more requests are served
      ErrorSt: begin
        lci_prog_idle_o = 1'b0;
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
      // Illegal code, lock up right away
      default: begin
        lci_prog_idle_o = 1'b0;
        state_d         = ErrorSt;
        fsm_err_o       = 1'b1;
      end
    endcase

    // Escalation or counter fault overrides every state
    if (lc_tx_test_true_loose(escalate_en_i) || cnt_err) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (error_q == NoError) begin
        error_d = FsmStateError;
      end
    end
  end

  ////////////////////
  // Word counter
  ////////////////////

  otp_word_counter #(
    .cnt_w (cnt_w)
  ) i_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clr_i  (cnt_clr),
    .incr_i (cnt_incr),
    .cnt_o  (cnt),
    .err_o  (cnt_err)
  );

  // Word address is partition offset plus count
  assign otp_addr_o = `OTP_LC_ADDR_W'(`OTP_LC_OFFSET) + `OTP_LC_ADDR_W'(cnt);

  assign data        = lc_data_i;
  // Data bus is quiet outside requests
  assign otp_wdata_o = otp_req_o ? data[cnt] : '0;

  assign error_o = error_q;

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetSt;
      error_q <= NoError;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/otp_word_counter.sv
/*
 * Redundant word counter
 * Keeps a true and an inverted copy and flags any mismatch
 */

`timescale 1ns/1ps
`default_nettype none

`include "otp_lc_cfg.svh"

module otp_word_counter #(
  parameter int cnt_w = $clog2(`OTP_LC_NUM_WORDS)
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clr_i,
  input  logic             incr_i,
  output logic [cnt_w-1:0] cnt_o,
  output logic             err_o
);

  // True count and its inverted shadow
  logic [cnt_w-1:0] cnt_q;
  logic [cnt_w-1:0] cnt_n_q;

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      cnt_n_q <= '1;
    end else if (clr_i) begin
      cnt_q   <= '0;
      cnt_n_q <= '1;
    end else if (incr_i) begin
      // Inverse of x + 1 equals ~x - 1
      cnt_q   <= cnt_q + cnt_w'(1);
      cnt_n_q <= cnt_n_q - cnt_w'(1);
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign cnt_o = cnt_q;

  // Any glitch in either copy breaks the inverse relation
  assign err_o = (cnt_q != ~cnt_n_q);

endmodule

`default_nettype wire

// File: logic/otp_lc_pkg.sv
/*
 * OTP life cycle package
 * Error codes, array commands and the escalation encoding
 */

`default_nettype none

package otp_lc_pkg;

  // Error codes reported by the fuse array and the FSM
  typedef enum logic [1:0] {
    NoError         = 2'd0,
    WriteBlankError = 2'd1,
    FsmStateError   = 2'd2
  } otp_err_e;

  // Fuse array command
  typedef enum logic {
    CmdRead  = 1'b0,
    CmdWrite = 1'b1
  } otp_cmd_e;

  // Multi-bit escalation signal
  // Only LcOff counts as inactive
  typedef enum logic [3:0] {
    LcOn  = 4'b1010,
    LcOff = 4'b0101
  } lc_tx_e;

  // Loose test, every code other than LcOff is active
  function automatic logic lc_tx_test_true_loose(lc_tx_e val);
    return val != LcOff;
  endfunction

endpackage

`default_nettype wire

// File: include/otp_lc_cfg.svh
/*
 * OTP life cycle programming path configuration
 * Word geometry, partition placement and fuse array timing
 */

`ifndef OTP_LC_CFG_SVH
`define OTP_LC_CFG_SVH

// Native OTP word width in bits
`define OTP_LC_WORD_W 16

// Words in one life cycle value (64 bits in total)
`define OTP_LC_NUM_WORDS 4

// Word address of the first life cycle word
`define OTP_LC_OFFSET 8

// Word address width and fuse array depth
`define OTP_LC_ADDR_W 5
`define OTP_LC_DEPTH 32

// Cycles from grant edge to response pulse
`define OTP_LC_RSP_DELAY 2

`endif
